//--- rtl/csi_pkg.sv
package csi_pkg;

	////////////////////
	// Lane layout

	// Data lanes on the receiver
	localparam int CSI_LANES = 4;

	// RAW8 pixel
	localparam int RAW_W = 8;

	// One receiver slot per lane, pixel sits in the upper bits
	localparam int RX_SLOT_W = 12;

	// Full receiver word, four slots
	localparam int RX_WORD_W = CSI_LANES * RX_SLOT_W;

	// Packed pixel word, lane 0 in the low byte
	localparam int PIX_WORD_W = CSI_LANES * RAW_W;

	////////////////////
	// Lane polarity

	// One bit per data lane, set where P and N are swapped on the board
	typedef logic [CSI_LANES-1:0] lane_flip_t;

endpackage

//--- rtl/bus_pkg.sv
package bus_pkg;

	////////////////////
	// Wishbone widths

	localparam int WB_AW = 16;
	localparam int WB_DW = 32;

	////////////////////
	// Register commands

	// Command byte width
	localparam int REG_CMD_W = 8;

	// Flash enable, bit 0
	localparam logic [REG_CMD_W-1:0] REG_FLASH_EN = 8'h00;
	// Backlight duty, bits 7..0
	localparam logic [REG_CMD_W-1:0] REG_PWM_DUTY = 8'h03;
	// Read-only status
	localparam logic [REG_CMD_W-1:0] REG_STATUS = 8'h04;

	// Status fields
	localparam int STAT_FCNT_W = 4;
	localparam int STAT_OVF_BIT = 8;

	////////////////////
	// Host address word

	// Region bit clear, frame-buffer word address
	typedef struct packed {
		logic region;
		logic [WB_AW-2:0] word;
	} mem_view_t;

	// Region bit set, command in the low byte
	typedef struct packed {
		logic region;
		logic [WB_AW-REG_CMD_W-2:0] rsvd;
		logic [REG_CMD_W-1:0] cmd;
	} reg_view_t;

	typedef union packed {
		mem_view_t mem;
		reg_view_t regv;
	} host_addr_u;

endpackage

//--- rtl/csi_lane_unpack.sv
module csi_lane_unpack
	import csi_pkg::*;
#(
	parameter lane_flip_t LANE_FLIP = 4'b0011
) (
	input  logic w_csi_rx_clk,
	input  logic w_sys_rstn,
	input  logic rx_vsync_i,
	input  logic rx_de_i,
	input  logic [RX_WORD_W-1:0] rx_data_i,
	output logic pix_valid_o,
	output logic [PIX_WORD_W-1:0] pix_word_o,
	output logic frame_start_o
);

	logic [PIX_WORD_W-1:0] pix_word_d;
	logic vsync_q;

	// Per lane: take upper 8 bits of the slot, undo polarity, reverse bits
	always_comb begin
		logic [RAW_W-1:0] lane_byte;
		pix_word_d = '0;
		for (int l = 0; l < CSI_LANES; l++) begin
			lane_byte = rx_data_i[l*RX_SLOT_W + (RX_SLOT_W-RAW_W) +: RAW_W];
			// Swapped pair shows up as inverted data
			lane_byte = lane_byte ^ {RAW_W{LANE_FLIP[l]}};
			for (int b = 0; b < RAW_W; b++) begin
				pix_word_d[l*RAW_W + b] = lane_byte[RAW_W-1-b];
			end
		end
	end

	// Pixel payload
	always_ff @(posedge w_csi_rx_clk) begin
		if (rx_de_i) begin
			pix_word_o <= pix_word_d;
		end
	end

	// Valid and frame start, one cycle behind the beat
	always_ff @(posedge w_csi_rx_clk or negedge w_sys_rstn) begin
		if (!w_sys_rstn) begin
			pix_valid_o <= 1'b0;
			vsync_q <= 1'b0;
			frame_start_o <= 1'b0;
		end else begin
			pix_valid_o <= rx_de_i;
			vsync_q <= rx_vsync_i;
			// Rising vsync
			frame_start_o <= rx_vsync_i && !vsync_q;
		end
	end

endmodule

//--- rtl/frame_writer.sv
module frame_writer
	import csi_pkg::*;
	import bus_pkg::*;
#(
	parameter int FIFO_DEPTH = 4,
	parameter int FB_AW = 10
) (
	input  logic w_csi_rx_clk,
	input  logic w_sys_rstn,
	input  logic pix_valid_i,
	input  logic [PIX_WORD_W-1:0] pix_word_i,
	input  logic frame_start_i,
	output logic wb_cyc_o,
	output logic wb_stb_o,
	output logic wb_we_o,
	output logic [WB_AW-1:0] wb_adr_o,
	output logic [WB_DW-1:0] wb_dat_o,
	input  logic wb_ack_i,
	output logic overflow_o
);

	localparam int PTR_W = (FIFO_DEPTH > 1) ? $clog2(FIFO_DEPTH) : 1;
	localparam int CNT_W = $clog2(FIFO_DEPTH + 1);

	// Word and its address travel together
	logic [PIX_WORD_W-1:0] fifo_word [FIFO_DEPTH];
	logic [FB_AW-1:0] fifo_adr [FIFO_DEPTH];

	logic [PTR_W-1:0] wr_ptr_q;
	logic [PTR_W-1:0] rd_ptr_q;
	logic [CNT_W-1:0] count_q;
	logic [FB_AW-1:0] wr_adr_q;
	logic [FB_AW-1:0] entry_adr;
	logic fifo_full;
	logic fifo_empty;
	logic push;
	logic pop;
	logic req_q;
	logic ovf_q;

	function automatic logic [PTR_W-1:0] ptr_next(input logic [PTR_W-1:0] ptr);
		ptr_next = (ptr == PTR_W'(FIFO_DEPTH - 1)) ? '0 : ptr + 1'b1;
	endfunction

	assign fifo_full = (count_q == CNT_W'(FIFO_DEPTH));
	assign fifo_empty = (count_q == '0);
	// Pixels never stall, a full FIFO drops the word
	assign push = pix_valid_i && !fifo_full;
	assign pop = req_q && wb_ack_i;
	// New frame restarts at word 0
	assign entry_adr = frame_start_i ? '0 : wr_adr_q;

	////////////////////
	// FIFO storage

	always_ff @(posedge w_csi_rx_clk) begin
		if (push) begin
			fifo_word[wr_ptr_q] <= pix_word_i;
			fifo_adr[wr_ptr_q] <= entry_adr;
		end
	end

	////////////////////
	// Pointers, address counter, bus request

	always_ff @(posedge w_csi_rx_clk or negedge w_sys_rstn) begin
		if (!w_sys_rstn) begin
			wr_ptr_q <= '0;
			rd_ptr_q <= '0;
			count_q <= '0;
			wr_adr_q <= '0;
			req_q <= 1'b0;
			ovf_q <= 1'b0;
		end else begin
			if (push) begin
				wr_ptr_q <= ptr_next(wr_ptr_q);
			end
			if (pop) begin
				rd_ptr_q <= ptr_next(rd_ptr_q);
			end
			case ({push, pop})
				2'b10: count_q <= count_q + 1'b1;
				2'b01: count_q <= count_q - 1'b1;
				default: ;
			endcase
			// Wraps at the buffer size
			if (push) begin
				wr_adr_q <= entry_adr + 1'b1;
			end else if (frame_start_i) begin
				wr_adr_q <= '0;
			end
			// One transfer per cyc, raised a cycle after data is queued
			if (pop) begin
				req_q <= 1'b0;
			end else if (!req_q && !fifo_empty) begin
				req_q <= 1'b1;
			end
			ovf_q <= pix_valid_i && fifo_full;
		end
	end

	// Head entry held until ack
	assign wb_cyc_o = req_q;
	assign wb_stb_o = req_q;
	assign wb_we_o = 1'b1;
	// Memory region, region bit stays clear
	assign wb_adr_o = {{(WB_AW-FB_AW){1'b0}}, fifo_adr[rd_ptr_q]};
	assign wb_dat_o = fifo_word[rd_ptr_q];
	assign overflow_o = ovf_q;

endmodule

//--- rtl/wb_interconnect.sv
module wb_interconnect
	import bus_pkg::*;
#(
	parameter int FB_AW = 10
) (
	input  logic w_csi_rx_clk,
	input  logic w_sys_rstn,
	// Master 0, frame writer
	input  logic m0_cyc_i,
	input  logic m0_stb_i,
	input  logic m0_we_i,
	input  logic [WB_AW-1:0] m0_adr_i,
	input  logic [WB_DW-1:0] m0_dat_i,
	output logic [WB_DW-1:0] m0_dat_o,
	output logic m0_ack_o,
	// Master 1, host
	input  logic m1_cyc_i,
	input  logic m1_stb_i,
	input  logic m1_we_i,
	input  logic [WB_AW-1:0] m1_adr_i,
	input  logic [WB_DW-1:0] m1_dat_i,
	output logic [WB_DW-1:0] m1_dat_o,
	output logic m1_ack_o,
	// Frame buffer slave
	output logic fb_stb_o,
	output logic fb_we_o,
	output logic [FB_AW-1:0] fb_adr_o,
	output logic [WB_DW-1:0] fb_dat_o,
	input  logic [WB_DW-1:0] fb_dat_i,
	input  logic fb_ack_i,
	// Register bank slave
	output logic reg_stb_o,
	output logic reg_we_o,
	output logic [REG_CMD_W-1:0] reg_cmd_o,
	output logic [WB_DW-1:0] reg_dat_o,
	input  logic [WB_DW-1:0] reg_dat_i,
	input  logic reg_ack_i
);

	logic busy_q;
	logic gnt_q;
	logic pri_q;
	logic req0;
	logic req1;
	logic gnt_d;
	logic g_cyc;
	logic g_stb;
	logic g_we;
	host_addr_u g_adr;
	logic [WB_DW-1:0] g_dat;
	logic bus_act;
	logic s_ack;
	logic [WB_DW-1:0] s_dat;

	assign req0 = m0_cyc_i && m0_stb_i;
	assign req1 = m1_cyc_i && m1_stb_i;

	////////////////////
	// Round-robin grant

	// Tie goes to the priority holder, otherwise the lone requester
	always_comb begin
		if (req0 && req1) begin
			gnt_d = pri_q;
		end else begin
			gnt_d = req1;
		end
	end

	always_ff @(posedge w_csi_rx_clk or negedge w_sys_rstn) begin
		if (!w_sys_rstn) begin
			busy_q <= 1'b0;
			gnt_q <= 1'b0;
			pri_q <= 1'b0;
		end else if (!busy_q) begin
			// Grant only changes on an idle bus
			if (req0 || req1) begin
				busy_q <= 1'b1;
				gnt_q <= gnt_d;
			end
		end else if (s_ack) begin
			// Other master goes first next time
			busy_q <= 1'b0;
			pri_q <= ~gnt_q;
		end else if (!g_cyc) begin
			// Master gave up the cycle
			busy_q <= 1'b0;
		end
	end

	////////////////////
	// Forward and decode

	assign g_cyc = gnt_q ? m1_cyc_i : m0_cyc_i;
	assign g_stb = gnt_q ? m1_stb_i : m0_stb_i;
	assign g_we = gnt_q ? m1_we_i : m0_we_i;
	assign g_adr = gnt_q ? m1_adr_i : m0_adr_i;
	assign g_dat = gnt_q ? m1_dat_i : m0_dat_i;

	assign bus_act = busy_q && g_cyc && g_stb;

	// Region bit picks the slave
	assign fb_stb_o = bus_act && !g_adr.mem.region;
	assign fb_we_o = g_we;
	assign fb_adr_o = g_adr.mem.word[FB_AW-1:0];
	assign fb_dat_o = g_dat;

	assign reg_stb_o = bus_act && g_adr.regv.region;
	assign reg_we_o = g_we;
	assign reg_cmd_o = g_adr.regv.cmd;
	assign reg_dat_o = g_dat;

	// Return path, granted master only
	assign s_ack = fb_ack_i || reg_ack_i;
	assign s_dat = g_adr.regv.region ? reg_dat_i : fb_dat_i;

	assign m0_ack_o = busy_q && !gnt_q && s_ack;
	assign m1_ack_o = busy_q && gnt_q && s_ack;
	assign m0_dat_o = gnt_q ? '0 : s_dat;
	assign m1_dat_o = gnt_q ? s_dat : '0;

endmodule

//--- rtl/frame_buffer.sv
module frame_buffer
	import bus_pkg::*;
#(
	parameter int FB_AW = 10
) (
	input  logic w_csi_rx_clk,
	input  logic w_sys_rstn,
	input  logic wb_stb_i,
	input  logic wb_we_i,
	input  logic [FB_AW-1:0] wb_adr_i,
	input  logic [WB_DW-1:0] wb_dat_i,
	output logic [WB_DW-1:0] wb_dat_o,
	output logic wb_ack_o
);

	localparam int FB_WORDS = 2 ** FB_AW;

	logic [WB_DW-1:0] mem [FB_WORDS];
	logic [WB_DW-1:0] rd_q;
	logic ack_q;
	logic first_beat;

	// First cycle of a strobe, before ack
	assign first_beat = wb_stb_i && !ack_q;

	// Single port, read returns the old word
	always_ff @(posedge w_csi_rx_clk) begin
		if (first_beat) begin
			if (wb_we_i) begin
				mem[wb_adr_i] <= wb_dat_i;
			end
			rd_q <= mem[wb_adr_i];
		end
	end

	// One-cycle ack, falls with stb
	always_ff @(posedge w_csi_rx_clk or negedge w_sys_rstn) begin
		if (!w_sys_rstn) begin
			ack_q <= 1'b0;
		end else begin
			ack_q <= first_beat;
		end
	end

	assign wb_dat_o = rd_q;
	assign wb_ack_o = ack_q;

endmodule

//--- rtl/board_ctrl.sv
module board_ctrl
	import bus_pkg::*;
(
	input  logic w_csi_rx_clk,
	input  logic w_sys_rstn,
	input  logic wb_stb_i,
	input  logic wb_we_i,
	input  logic [REG_CMD_W-1:0] wb_cmd_i,
	input  logic [WB_DW-1:0] wb_dat_i,
	output logic [WB_DW-1:0] wb_dat_o,
	output logic wb_ack_o,
	input  logic frame_start_i,
	input  logic overflow_i,
	input  logic spi_ssn_i,
	input  logic spi_sck_i,
	input  logic i2c_scl_i,
	output logic spi_cs_o,
	output logic spi_sck_o,
	output logic pwm_o,
	output logic led_o
);

	localparam int PWM_W = 12;

	logic ack_q;
	logic first_beat;
	logic wr_en;
	logic rd_status;
	logic flash_en_q;
	logic [7:0] duty_q;
	logic [STAT_FCNT_W-1:0] fcnt_q;
	logic ovf_q;
	logic [PWM_W-1:0] pwm_cnt_q;
	logic pwm_q;
	logic [WB_DW-1:0] rd_d;
	logic [WB_DW-1:0] rd_q;

	assign first_beat = wb_stb_i && !ack_q;
	// Writes land with the ack
	assign wr_en = first_beat && wb_we_i;
	assign rd_status = first_beat && !wb_we_i && (wb_cmd_i == REG_STATUS);

	////////////////////
	// Register file

	always_comb begin
		rd_d = '0;
		case (wb_cmd_i)
			REG_FLASH_EN: rd_d[0] = flash_en_q;
			REG_PWM_DUTY: rd_d[7:0] = duty_q;
			REG_STATUS: begin
				rd_d[STAT_FCNT_W-1:0] = fcnt_q;
				rd_d[STAT_OVF_BIT] = ovf_q;
			end
			default: ;
		endcase
	end

	always_ff @(posedge w_csi_rx_clk) begin
		if (first_beat) begin
			rd_q <= rd_d;
		end
	end

	always_ff @(posedge w_csi_rx_clk or negedge w_sys_rstn) begin
		if (!w_sys_rstn) begin
			ack_q <= 1'b0;
			flash_en_q <= 1'b0;
			duty_q <= '0;
			fcnt_q <= '0;
			ovf_q <= 1'b0;
		end else begin
			ack_q <= first_beat;
			if (wr_en && (wb_cmd_i == REG_FLASH_EN)) begin
				flash_en_q <= wb_dat_i[0];
			end
			if (wr_en && (wb_cmd_i == REG_PWM_DUTY)) begin
				duty_q <= wb_dat_i[7:0];
			end
			// Wraps at 16 frames
			if (frame_start_i) begin
				fcnt_q <= fcnt_q + 1'b1;
			end
			// Sticky, a new drop beats the clearing read
			if (overflow_i) begin
				ovf_q <= 1'b1;
			end else if (rd_status) begin
				ovf_q <= 1'b0;
			end
		end
	end

	////////////////////
	// Backlight PWM

	// Duty scaled to 12 bits, zero keeps the backlight off
	always_ff @(posedge w_csi_rx_clk or negedge w_sys_rstn) begin
		if (!w_sys_rstn) begin
			pwm_cnt_q <= '0;
			pwm_q <= 1'b0;
		end else begin
			pwm_cnt_q <= pwm_cnt_q + 1'b1;
			pwm_q <= ({duty_q, 4'b0000} > pwm_cnt_q);
		end
	end

	// Shared pins, flash owns them only when enabled
	assign spi_cs_o = flash_en_q ? spi_ssn_i : 1'b1;
	assign spi_sck_o = flash_en_q ? spi_sck_i : i2c_scl_i;

	assign pwm_o = pwm_q;
	// Toggles every 8 frames
	assign led_o = fcnt_q[STAT_FCNT_W-1];
	assign wb_dat_o = rd_q;
	assign wb_ack_o = ack_q;

endmodule

//--- rtl/csi_capture_top.sv
module csi_capture_top
	import csi_pkg::*;
	import bus_pkg::*;
#(
	parameter lane_flip_t LANE_FLIP = 4'b0011,
	parameter int FB_AW = 10,
	parameter int FIFO_DEPTH = 4
) (
	input  logic w_csi_rx_clk,
	input  logic w_sys_rstn,
	// Receiver output
	input  logic rx_vsync_i,
	input  logic rx_de_i,
	input  logic [RX_WORD_W-1:0] rx_data_i,
	// Host master port
	input  logic host_cyc_i,
	input  logic host_stb_i,
	input  logic host_we_i,
	input  logic [WB_AW-1:0] host_adr_i,
	input  logic [WB_DW-1:0] host_dat_i,
	output logic [WB_DW-1:0] host_dat_o,
	output logic host_ack_o,
	// Board pins
	input  logic spi_ssn_i,
	input  logic spi_sck_i,
	input  logic i2c_scl_i,
	output logic spi_cs_o,
	output logic spi_sck_o,
	output logic pwm_o,
	output logic led_o
);

	// Capture path
	logic pix_valid;
	logic [PIX_WORD_W-1:0] pix_word;
	logic frame_start;
	logic overflow;

	// Writer master
	logic m0_cyc;
	logic m0_stb;
	logic m0_we;
	logic [WB_AW-1:0] m0_adr;
	logic [WB_DW-1:0] m0_dat;
	logic m0_ack;

	// Slave ports
	logic fb_stb;
	logic fb_we;
	logic [FB_AW-1:0] fb_adr;
	logic [WB_DW-1:0] fb_wdat;
	logic [WB_DW-1:0] fb_rdat;
	logic fb_ack;
	logic reg_stb;
	logic reg_we;
	logic [REG_CMD_W-1:0] reg_cmd;
	logic [WB_DW-1:0] reg_wdat;
	logic [WB_DW-1:0] reg_rdat;
	logic reg_ack;

	////////////////////
	// Capture path

	csi_lane_unpack #(.LANE_FLIP(LANE_FLIP)) u_unpack (
		.w_csi_rx_clk(w_csi_rx_clk), .w_sys_rstn(w_sys_rstn),
		.rx_vsync_i(rx_vsync_i), .rx_de_i(rx_de_i), .rx_data_i(rx_data_i),
		.pix_valid_o(pix_valid), .pix_word_o(pix_word), .frame_start_o(frame_start)
	);

	frame_writer #(.FIFO_DEPTH(FIFO_DEPTH), .FB_AW(FB_AW)) u_writer (
		.w_csi_rx_clk(w_csi_rx_clk), .w_sys_rstn(w_sys_rstn),
		.pix_valid_i(pix_valid), .pix_word_i(pix_word), .frame_start_i(frame_start),
		.wb_cyc_o(m0_cyc), .wb_stb_o(m0_stb), .wb_we_o(m0_we),
		.wb_adr_o(m0_adr), .wb_dat_o(m0_dat), .wb_ack_i(m0_ack),
		.overflow_o(overflow)
	);

	////////////////////
	// Shared bus

	// Writer never reads, its return data is left open
	wb_interconnect #(.FB_AW(FB_AW)) u_bus (
		.w_csi_rx_clk(w_csi_rx_clk), .w_sys_rstn(w_sys_rstn),
		.m0_cyc_i(m0_cyc), .m0_stb_i(m0_stb), .m0_we_i(m0_we),
		.m0_adr_i(m0_adr), .m0_dat_i(m0_dat), .m0_dat_o(), .m0_ack_o(m0_ack),
		.m1_cyc_i(host_cyc_i), .m1_stb_i(host_stb_i), .m1_we_i(host_we_i),
		.m1_adr_i(host_adr_i), .m1_dat_i(host_dat_i),
		.m1_dat_o(host_dat_o), .m1_ack_o(host_ack_o),
		.fb_stb_o(fb_stb), .fb_we_o(fb_we), .fb_adr_o(fb_adr),
		.fb_dat_o(fb_wdat), .fb_dat_i(fb_rdat), .fb_ack_i(fb_ack),
		.reg_stb_o(reg_stb), .reg_we_o(reg_we), .reg_cmd_o(reg_cmd),
		.reg_dat_o(reg_wdat), .reg_dat_i(reg_rdat), .reg_ack_i(reg_ack)
	);

	frame_buffer #(.FB_AW(FB_AW)) u_fb (
		.w_csi_rx_clk(w_csi_rx_clk), .w_sys_rstn(w_sys_rstn),
		.wb_stb_i(fb_stb), .wb_we_i(fb_we), .wb_adr_i(fb_adr),
		.wb_dat_i(fb_wdat), .wb_dat_o(fb_rdat), .wb_ack_o(fb_ack)
	);

	board_ctrl u_ctrl (
		.w_csi_rx_clk(w_csi_rx_clk), .w_sys_rstn(w_sys_rstn),
		.wb_stb_i(reg_stb), .wb_we_i(reg_we), .wb_cmd_i(reg_cmd),
		.wb_dat_i(reg_wdat), .wb_dat_o(reg_rdat), .wb_ack_o(reg_ack),
		.frame_start_i(frame_start), .overflow_i(overflow),
		.spi_ssn_i(spi_ssn_i), .spi_sck_i(spi_sck_i), .i2c_scl_i(i2c_scl_i),
		.spi_cs_o(spi_cs_o), .spi_sck_o(spi_sck_o), .pwm_o(pwm_o), .led_o(led_o)
	);

endmodule

//--- tb/tb_asserts.sv
module tb_asserts (
	input logic clk_i,
	input logic rstn_i,
	input logic m0_stb_i,
	input logic m0_ack_i,
	input logic [15:0] m0_adr_i,
	input logic m1_stb_i,
	input logic m1_ack_i,
	input logic [15:0] m1_adr_i,
	input logic fb_ack_i,
	input logic reg_ack_i
);
	timeunit 1ns;
	timeprecision 1ps;

	// Failed assertions so far
	int fail_count = 0;

	// Ack only with a live strobe
	ack_needs_stb: assert property (@(posedge clk_i) disable iff (!rstn_i)
		(m0_ack_i |-> m0_stb_i) and (m1_ack_i |-> m1_stb_i))
		else begin
			$error("ack without stb");
			fail_count++;
		end

	// Slaves never answer together
	one_slave_ack: assert property (@(posedge clk_i) disable iff (!rstn_i)
		!(fb_ack_i && reg_ack_i))
		else begin
			$error("both slave acks high");
			fail_count++;
		end

	// Address held while waiting
	m0_adr_held: assert property (@(posedge clk_i) disable iff (!rstn_i)
		(m0_stb_i && !m0_ack_i) |=> $stable(m0_adr_i))
		else begin
			$error("writer address moved before ack");
			fail_count++;
		end
	m1_adr_held: assert property (@(posedge clk_i) disable iff (!rstn_i)
		(m1_stb_i && !m1_ack_i) |=> $stable(m1_adr_i))
		else begin
			$error("host address moved before ack");
			fail_count++;
		end

endmodule

bind wb_interconnect tb_asserts u_asserts (
	.clk_i(w_csi_rx_clk), .rstn_i(w_sys_rstn),
	.m0_stb_i(m0_stb_i), .m0_ack_i(m0_ack_o), .m0_adr_i(m0_adr_i),
	.m1_stb_i(m1_stb_i), .m1_ack_i(m1_ack_o), .m1_adr_i(m1_adr_i),
	.fb_ack_i(fb_ack_i), .reg_ack_i(reg_ack_i)
);

//--- tb/tb_checker.sv
module tb_checker
	import csi_pkg::*;
	import bus_pkg::*;
#(
	parameter lane_flip_t LANE_FLIP = 4'b0011,
	parameter int FB_AW = 10
) (
	input  logic clk_i,
	input  logic rstn_i,
	input  logic rx_vsync_i,
	input  logic rx_de_i,
	input  logic [RX_WORD_W-1:0] rx_data_i,
	input  logic host_cyc_i,
	input  logic host_we_i,
	input  logic [WB_AW-1:0] host_adr_i,
	input  logic [WB_DW-1:0] host_dat_i,
	input  logic [WB_DW-1:0] host_rdat_i,
	input  logic host_ack_i,
	input  logic spi_ssn_i,
	input  logic spi_sck_i,
	input  logic i2c_scl_i,
	input  logic spi_cs_i,
	input  logic spi_sck_pin_i,
	input  logic pwm_i,
	input  logic led_i,
	input  logic pwm_meas_i,
	input  logic ovf_mark_i,
	output logic pwm_busy_o,
	output int err_count_o
);
	timeunit 1ns;
	timeprecision 1ps;

	// Model state
	logic [WB_DW-1:0] mem_model [2**FB_AW];
	bit mem_ok [2**FB_AW];
	logic [FB_AW-1:0] wr_adr;
	logic vsync_q;
	logic flash_en;
	logic [7:0] duty;
	logic [3:0] fcnt;
	logic ovf_model;
	int pwm_left;
	int pwm_high;

	// Lane byte from slot top, undo swap, reverse bits, lane 0 lowest
	function automatic logic [WB_DW-1:0] expected_word(input logic [RX_WORD_W-1:0] rx);
		logic [7:0] px;
		logic [WB_DW-1:0] w;
		w = '0;
		for (int l = 0; l < 4; l++) begin
			px = rx[l*12 + 4 +: 8];
			if (LANE_FLIP[l]) begin
				px = ~px;
			end
			for (int b = 0; b < 8; b++) begin
				w[l*8 + b] = px[7-b];
			end
		end
		return w;
	endfunction

	task automatic compare(input string name, input logic [WB_DW-1:0] exp,
			input logic [WB_DW-1:0] got);
		if (got !== exp) begin
			$display("error t=%0t %s expected %h got %h", $time, name, exp, got);
			err_count_o++;
		end
	endtask

	////////////////////
	// Bus transfers

	task automatic check_transfer();
		logic [WB_DW-1:0] exp;
		exp = '0;
		if (!host_adr_i[WB_AW-1]) begin
			if (host_we_i) begin
				mem_model[host_adr_i[FB_AW-1:0]] = host_dat_i;
				mem_ok[host_adr_i[FB_AW-1:0]] = 1'b1;
			end else if (mem_ok[host_adr_i[FB_AW-1:0]]) begin
				compare("host_dat_o", mem_model[host_adr_i[FB_AW-1:0]], host_rdat_i);
			end
		end else begin
			case (host_adr_i[7:0])
				REG_FLASH_EN: begin
					if (host_we_i) flash_en = host_dat_i[0];
					else compare("host_dat_o", {31'b0, flash_en}, host_rdat_i);
				end
				REG_PWM_DUTY: begin
					if (host_we_i) duty = host_dat_i[7:0];
					else compare("host_dat_o", {24'b0, duty}, host_rdat_i);
				end
				REG_STATUS: begin
					exp[3:0] = fcnt;
					exp[8] = ovf_model;
					compare("host_dat_o", exp, host_rdat_i);
					compare("led_o", {31'b0, fcnt[3]}, {31'b0, led_i});
					// Read clears the sticky flag
					ovf_model = 1'b0;
				end
				default: ;
			endcase
		end
	endtask

	// Everything sampled mid-cycle
	always @(negedge clk_i or negedge rstn_i) begin
		if (!rstn_i) begin
			for (int i = 0; i < 2**FB_AW; i++) mem_ok[i] = 1'b0;
			wr_adr = '0;
			vsync_q = 1'b0;
			flash_en = 1'b0;
			duty = '0;
			fcnt = '0;
			ovf_model = 1'b0;
			pwm_left = 0;
			pwm_high = 0;
			pwm_busy_o = 1'b0;
			err_count_o = 0;
		end else begin
			// New frame writes from word 0
			if (rx_vsync_i && !vsync_q) begin
				wr_adr = '0;
				fcnt = fcnt + 1'b1;
			end
			vsync_q = rx_vsync_i;
			if (rx_de_i) begin
				mem_model[wr_adr] = expected_word(rx_data_i);
				mem_ok[wr_adr] = 1'b1;
				wr_adr = wr_adr + 1'b1;
			end
			if (ovf_mark_i) ovf_model = 1'b1;
			if (host_ack_i && host_cyc_i) check_transfer();
			// Shared pin mux
			compare("spi_cs_o", {31'b0, flash_en ? spi_ssn_i : 1'b1}, {31'b0, spi_cs_i});
			compare("spi_sck_o", {31'b0, flash_en ? spi_sck_i : i2c_scl_i},
				{31'b0, spi_sck_pin_i});
			////////////////////
			// PWM window of one full period
			if (pwm_left > 0) begin
				if (pwm_i) pwm_high++;
				pwm_left--;
				if (pwm_left == 0) begin
					compare("pwm_o high count", {20'b0, duty, 4'b0000}, 32'(pwm_high));
					pwm_busy_o = 1'b0;
				end
			end else if (pwm_meas_i) begin
				pwm_left = 4096;
				pwm_high = 0;
				pwm_busy_o = 1'b1;
			end
		end
	end

endmodule

//--- tb/tb_top.sv
module tb_top
	import csi_pkg::*;
	import bus_pkg::*;
;
	timeunit 1ns;
	timeprecision 1ps;

	localparam lane_flip_t LANE_FLIP = 4'b0011;
	localparam int FB_AW = 10;
	localparam int FIFO_DEPTH = 4;

	// Test lengths
	localparam int N_FRAME1 = 12;
	localparam int N_FRAME2 = 6;
	localparam int N_SHORT = 7;
	localparam int SHORT_LEN = 2;
	localparam int N_BURST = 16;
	localparam int N_REG_LOOPS = 6;
	localparam int N_PWM = 2;
	localparam int N_FRAMES = 2 + N_SHORT + 1;
	localparam int N_BEATS = N_FRAME1 + N_FRAME2 + N_SHORT * SHORT_LEN + N_BURST;
	localparam int N_HOST = 2 * N_FRAME1 + 4 * N_REG_LOOPS + N_PWM + 4;
	// Frame overhead, paced beats, host accesses, PWM windows
	localparam int RUN_CYCLES = N_FRAMES * 40 + N_BEATS * 8 + N_HOST * 20 + N_PWM * 4200 + 100;

	logic clk;
	logic rstn;
	logic rx_vsync;
	logic rx_de;
	logic [RX_WORD_W-1:0] rx_data;
	logic host_cyc;
	logic host_stb;
	logic host_we;
	logic [WB_AW-1:0] host_adr;
	logic [WB_DW-1:0] host_dat;
	logic [WB_DW-1:0] host_rdat;
	logic host_ack;
	logic spi_ssn;
	logic spi_sck;
	logic i2c_scl;
	logic spi_cs;
	logic spi_sck_pin;
	logic pwm;
	logic led;
	logic pwm_meas;
	logic ovf_mark;
	logic pwm_busy;
	int chk_errs;
	int bus_errs;
	int seed;

	csi_capture_top #(.LANE_FLIP(LANE_FLIP), .FB_AW(FB_AW), .FIFO_DEPTH(FIFO_DEPTH)) dut_i (
		.w_csi_rx_clk(clk), .w_sys_rstn(rstn),
		.rx_vsync_i(rx_vsync), .rx_de_i(rx_de), .rx_data_i(rx_data),
		.host_cyc_i(host_cyc), .host_stb_i(host_stb), .host_we_i(host_we),
		.host_adr_i(host_adr), .host_dat_i(host_dat),
		.host_dat_o(host_rdat), .host_ack_o(host_ack),
		.spi_ssn_i(spi_ssn), .spi_sck_i(spi_sck), .i2c_scl_i(i2c_scl),
		.spi_cs_o(spi_cs), .spi_sck_o(spi_sck_pin), .pwm_o(pwm), .led_o(led)
	);

	tb_checker #(.LANE_FLIP(LANE_FLIP), .FB_AW(FB_AW)) u_checker (
		.clk_i(clk), .rstn_i(rstn),
		.rx_vsync_i(rx_vsync), .rx_de_i(rx_de), .rx_data_i(rx_data),
		.host_cyc_i(host_cyc), .host_we_i(host_we), .host_adr_i(host_adr),
		.host_dat_i(host_dat), .host_rdat_i(host_rdat), .host_ack_i(host_ack),
		.spi_ssn_i(spi_ssn), .spi_sck_i(spi_sck), .i2c_scl_i(i2c_scl),
		.spi_cs_i(spi_cs), .spi_sck_pin_i(spi_sck_pin), .pwm_i(pwm), .led_i(led),
		.pwm_meas_i(pwm_meas), .ovf_mark_i(ovf_mark),
		.pwm_busy_o(pwm_busy), .err_count_o(chk_errs)
	);

	////////////////////
	// Clock and watchdog

	initial begin
		clk = 1'b0;
		forever #50 clk = ~clk;
	end

	initial begin
		#(RUN_CYCLES * 2 * 100);
		$display("watchdog expired before the tests finished");
		$display("Test FAILED");
		$finish;
	end

	// Shared pins toggle randomly the whole run
	always @(posedge clk) begin
		spi_ssn <= 1'($random(seed));
		spi_sck <= 1'($random(seed));
		i2c_scl <= 1'($random(seed));
	end

	////////////////////
	// Stimulus tasks

	task automatic wait_cycles(input int n);
		repeat (n) @(posedge clk);
	endtask

	// One vsync pulse, then beats, paced or back to back
	task automatic send_frame(input int beats, input bit paced);
		int gap;
		@(posedge clk);
		rx_vsync <= 1'b1;
		wait_cycles(2);
		rx_vsync <= 1'b0;
		wait_cycles(2);
		for (int i = 0; i < beats; i++) begin
			rx_de <= 1'b1;
			rx_data <= {16'($random(seed)), 32'($random(seed))};
			@(posedge clk);
			if (paced) begin
				rx_de <= 1'b0;
				gap = 3 + int'($unsigned($random(seed)) % 3);
				wait_cycles(gap);
			end
		end
		rx_de <= 1'b0;
		wait_cycles(30);
	endtask

	// Single Wishbone classic transfer held until ack
	task automatic host_access(input bit we, input logic [WB_AW-1:0] adr,
			input logic [WB_DW-1:0] dat);
		int waited;
		waited = 0;
		@(posedge clk);
		host_cyc <= 1'b1;
		host_stb <= 1'b1;
		host_we <= we;
		host_adr <= adr;
		host_dat <= dat;
		@(posedge clk);
		while (!host_ack && waited < 100) begin
			@(posedge clk);
			waited++;
		end
		if (!host_ack) begin
			$display("host access to address %h was never acknowledged", adr);
			bus_errs++;
		end
		host_cyc <= 1'b0;
		host_stb <= 1'b0;
		host_we <= 1'b0;
	endtask

	////////////////////
	// Test sequence

	initial begin
		seed = 73;
		bus_errs = 0;
		rstn = 1'b0;
		rx_vsync = 1'b0;
		rx_de = 1'b0;
		rx_data = '0;
		host_cyc = 1'b0;
		host_stb = 1'b0;
		host_we = 1'b0;
		host_adr = '0;
		host_dat = '0;
		spi_ssn = 1'b1;
		spi_sck = 1'b0;
		i2c_scl = 1'b0;
		pwm_meas = 1'b0;
		ovf_mark = 1'b0;
		wait_cycles(10);
		rstn <= 1'b1;
		wait_cycles(5);

		// Capture, then restart over a shorter frame
		send_frame(N_FRAME1, 1'b1);
		for (int i = 0; i < N_FRAME1; i++) begin
			host_access(1'b0, 16'(i), '0);
		end
		send_frame(N_FRAME2, 1'b1);
		for (int i = 0; i < N_FRAME1; i++) begin
			host_access(1'b0, 16'(i), '0);
		end

		// Two frames so far, LED still dark
		host_access(1'b0, {8'h80, REG_STATUS}, '0);

		// Register readback while the checker watches the pin mux
		for (int i = 0; i < N_REG_LOOPS; i++) begin
			host_access(1'b1, {8'h80, REG_FLASH_EN}, $random(seed));
			host_access(1'b0, {8'h80, REG_FLASH_EN}, '0);
			host_access(1'b1, {8'h80, REG_PWM_DUTY}, $random(seed));
			host_access(1'b0, {8'h80, REG_PWM_DUTY}, '0);
			wait_cycles(3 + int'($unsigned($random(seed)) % 8));
		end

		// PWM windows
		for (int k = 0; k < N_PWM; k++) begin
			host_access(1'b1, {8'h80, REG_PWM_DUTY}, $random(seed));
			wait_cycles(4);
			pwm_meas <= 1'b1;
			@(posedge clk);
			pwm_meas <= 1'b0;
			wait_cycles(2);
			while (pwm_busy) begin
				@(posedge clk);
			end
		end

		// Enough frames to reach LED bit
		for (int i = 0; i < N_SHORT; i++) begin
			send_frame(SHORT_LEN, 1'b1);
		end
		host_access(1'b0, {8'h80, REG_STATUS}, '0);

		// Back-to-back beats overrun the FIFO
		send_frame(N_BURST, 1'b0);
		ovf_mark <= 1'b1;
		@(posedge clk);
		ovf_mark <= 1'b0;
		host_access(1'b0, {8'h80, REG_STATUS}, '0);
		host_access(1'b0, {8'h80, REG_STATUS}, '0);

		wait_cycles(5);
		$display("errors: checker %0d, host bus %0d, assertions %0d",
			chk_errs, bus_errs, dut_i.u_bus.u_asserts.fail_count);
		if (chk_errs == 0 && bus_errs == 0 && dut_i.u_bus.u_asserts.fail_count == 0) begin
			$display("Test OK");
		end else begin
			$display("Test FAILED");
		end
		$finish;
	end

endmodule

//--- sources.f
rtl/csi_pkg.sv
rtl/bus_pkg.sv
rtl/csi_lane_unpack.sv
rtl/frame_writer.sv
rtl/wb_interconnect.sv
rtl/frame_buffer.sv
rtl/board_ctrl.sv
rtl/csi_capture_top.sv
tb/tb_asserts.sv
tb/tb_checker.sv
tb/tb_top.sv

//--- Makefile
VERILATOR ?= verilator
TOP ?= tb_top
FILELIST ?= sources.f
OBJ_DIR ?= obj_dir
VFLAGS ?= --binary --timing --assert --timescale 1ns/1ps
PASS_MSG ?= Test OK

.PHONY: help build test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator and run the testbench"
	@echo "  clean  remove build output"
	@echo "  help   show this list"

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)

test: build
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)
